//--- Makefile
TOP := tb_inference_request_preprocessor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f inference_request_preprocessor.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" sim.log; then \
		echo "Run ended without a result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- beat_stage.sv
`timescale 1ns/1ns
`default_nettype none

module beat_stage (
    input  wire logic           axis_aclk,
    input  wire logic           axis_resetn,

    input  wire irp_pkg::beat_t body_in,
    input  wire logic           last_packet,

    input  wire logic           accept,
    input  wire logic           insert_marker,

    output irp_pkg::beat_t      wr_beat,
    output logic                wr_en
);

    // Beat register, written one cycle after acceptance
    always_ff @(posedge axis_aclk) begin
        if (insert_marker) begin
            // Empty beat closing an aborted request
            wr_beat.data <= '0;
            wr_beat.keep <= '0;
            wr_beat.last <= 1'b1;
        end else if (accept) begin
            wr_beat.data <= body_in.data;
            wr_beat.keep <= body_in.keep;
            // Only the final packet of the request ends the output frame
            wr_beat.last <= body_in.last && last_packet;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept || insert_marker;
        end
    end

    // The control FSM drops the beat that raised the error
    accept_xor_marker: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        !(accept && insert_marker)
    );

endmodule

`default_nettype wire

//--- body_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module body_fifo #(
    parameter int FIFO_DEPTH_BITS = irp_pkg::FIFO_DEPTH_BITS
) (
    input  wire logic           axis_aclk,
    input  wire logic           axis_resetn,

    input  wire logic           flush,

    input  wire irp_pkg::beat_t wr_beat,
    input  wire logic           wr_en,

    output irp_pkg::beat_t      body_out,
    output logic                body_out_valid,
    input  wire logic           body_out_ready,

    output logic                nearly_full,
    output logic                empty
);

    import irp_pkg::*;

    localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

    beat_t mem [DEPTH];

    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;
    logic [FIFO_DEPTH_BITS-1:0] wr_addr;

    logic rd_en;
    logic full;

    assign empty       = (count == '0);
    assign full        = (int'(count) == DEPTH);
    assign nearly_full = (int'(count) >= DEPTH - NEARLY_FULL_MARGIN);

    // Fall-through read port
    assign body_out       = mem[rd_ptr];
    assign body_out_valid = !empty;
    assign rd_en          = body_out_valid && body_out_ready;

    // A flush restarts at slot zero, so a same-edge write lands there
    assign wr_addr = flush ? '0 : wr_ptr;

    always_ff @(posedge axis_aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= {{(FIFO_DEPTH_BITS-1){1'b0}}, wr_en};
            count  <= {{FIFO_DEPTH_BITS{1'b0}}, wr_en};
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // Nearly-full back-pressure must cover the write pipeline
    no_write_when_full: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (wr_en && !flush) |-> !full
    );

    // Pointers must agree that the queue holds a beat
    no_read_when_empty: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        rd_en |-> (rd_ptr != wr_ptr) || full
    );

endmodule

`default_nettype wire

//--- flow_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module flow_tracker (
    input  wire logic               axis_aclk,
    input  wire logic               axis_resetn,

    input  wire irp_pkg::pkt_meta_t meta_in,

    input  wire logic               capture_flow,
    input  wire logic               advance_seq,

    output irp_pkg::flow_key_t      flow_out,
    output logic                    same_flow,
    output logic                    first_seq_ok,
    output logic                    next_seq_ok
);

    import irp_pkg::*;

    flow_key_t            flow_q;
    logic [SEQ_WIDTH-1:0] seq_q;

    logic [SEQ_WIDTH-1:0] seq_logical_in;
    logic [SEQ_WIDTH-1:0] seq_logical_q;

    // Network order to host order
    function automatic logic [SEQ_WIDTH-1:0] byte_swap(input logic [SEQ_WIDTH-1:0] value);
        logic [SEQ_WIDTH-1:0] swapped;
        swapped = '0;
        for (int i = 0; i < SEQ_WIDTH / 8; i++) begin
            swapped[i*8 +: 8] = value[(SEQ_WIDTH/8 - 1 - i)*8 +: 8];
        end
        return swapped;
    endfunction

    assign seq_logical_in = byte_swap(meta_in.seq_num);
    assign seq_logical_q  = byte_swap(seq_q);

    // All seven key fields must agree
    assign same_flow    = (meta_in.flow == flow_q);
    assign first_seq_ok = (seq_logical_in == '0);
    assign next_seq_ok  = (seq_logical_in == SEQ_WIDTH'(seq_logical_q + 1'b1));

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            flow_q <= '0;
            seq_q  <= '0;
        end else begin
            if (capture_flow) begin
                flow_q <= meta_in.flow;
            end
            // Stored in wire order, swapped only for the compare
            if (capture_flow || advance_seq) begin
                seq_q <= meta_in.seq_num;
            end
        end
    end

    assign flow_out = flow_q;

endmodule

`default_nettype wire

//--- inference_request_preprocessor.f
irp_pkg.sv
request_control.sv
flow_tracker.sv
beat_stage.sv
body_fifo.sv
inference_request_preprocessor.sv
tb_inference_request_preprocessor.sv

//--- inference_request_preprocessor.sv
`timescale 1ns/1ns
`default_nettype none

module inference_request_preprocessor (
    input  wire logic               axis_aclk,
    input  wire logic               axis_resetn,

    // Request body stream with packet metadata
    input  wire irp_pkg::beat_t     body_in,
    input  wire logic               body_in_valid,
    output logic                    body_in_ready,
    input  wire irp_pkg::pkt_meta_t meta_in,

    // Queued body stream
    output irp_pkg::beat_t          body_out,
    output logic                    body_out_valid,
    input  wire logic               body_out_ready,

    // Current request status
    output irp_pkg::flow_key_t      flow_out,
    output logic                    error_out
);

    import irp_pkg::*;

    logic accept;
    logic capture_flow;
    logic advance_seq;
    logic insert_marker;
    logic flush;

    logic same_flow;
    logic first_seq_ok;
    logic next_seq_ok;

    logic nearly_full;
    logic empty;

    beat_t wr_beat;
    logic  wr_en;

    request_control u_request_control (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .body_in_valid (body_in_valid),
        .body_in_ready (body_in_ready),
        .body_in_last  (body_in.last),
        .last_packet   (meta_in.last_packet),
        .same_flow     (same_flow),
        .first_seq_ok  (first_seq_ok),
        .next_seq_ok   (next_seq_ok),
        .nearly_full   (nearly_full),
        .empty         (empty),
        .accept        (accept),
        .capture_flow  (capture_flow),
        .advance_seq   (advance_seq),
        .insert_marker (insert_marker),
        .flush         (flush),
        .error_out     (error_out)
    );

    flow_tracker u_flow_tracker (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .meta_in      (meta_in),
        .capture_flow (capture_flow),
        .advance_seq  (advance_seq),
        .flow_out     (flow_out),
        .same_flow    (same_flow),
        .first_seq_ok (first_seq_ok),
        .next_seq_ok  (next_seq_ok)
    );

    beat_stage u_beat_stage (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .body_in       (body_in),
        .last_packet   (meta_in.last_packet),
        .accept        (accept),
        .insert_marker (insert_marker),
        .wr_beat       (wr_beat),
        .wr_en         (wr_en)
    );

    body_fifo #(
        .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
    ) u_body_fifo (
        .axis_aclk      (axis_aclk),
        .axis_resetn    (axis_resetn),
        .flush          (flush),
        .wr_beat        (wr_beat),
        .wr_en          (wr_en),
        .body_out       (body_out),
        .body_out_valid (body_out_valid),
        .body_out_ready (body_out_ready),
        .nearly_full    (nearly_full),
        .empty          (empty)
    );

endmodule

`default_nettype wire

//--- irp_pkg.sv
`default_nettype none

package irp_pkg;

    // Stream geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // Flow key field widths
    localparam int MAC_WIDTH  = 48;
    localparam int IP_WIDTH   = 32;
    localparam int PORT_WIDTH = 16;
    localparam int TID_WIDTH  = 32;
    localparam int SEQ_WIDTH  = 16;

    // Body queue sizing
    localparam int FIFO_DEPTH_BITS    = 4;
    // Free entries still left when nearly_full rises
    localparam int NEARLY_FULL_MARGIN = 2;

    // Identifies one inference request
    typedef struct packed {
        logic [MAC_WIDTH-1:0]  src_mac;
        logic [MAC_WIDTH-1:0]  dest_mac;
        logic [IP_WIDTH-1:0]   src_ip;
        logic [IP_WIDTH-1:0]   dest_ip;
        logic [PORT_WIDTH-1:0] src_port;
        logic [PORT_WIDTH-1:0] dest_port;
        logic [TID_WIDTH-1:0]  transmission_id;
    } flow_key_t;

    // Per-packet metadata, steady for all beats of a packet
    typedef struct packed {
        flow_key_t            flow;
        // Network byte order
        logic [SEQ_WIDTH-1:0] seq_num;
        logic                 last_packet;
    } pkt_meta_t;

    // One stream beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
    } beat_t;

    // Request tracking states
    typedef enum logic [1:0] {
        WAIT_FIRST,
        RECEIVING,
        WAIT_NEXT,
        DRAINING
    } req_state_e;

endpackage

`default_nettype wire

//--- request_control.sv
`timescale 1ns/1ns
`default_nettype none

module request_control (
    input  wire logic axis_aclk,
    input  wire logic axis_resetn,

    input  wire logic body_in_valid,
    output logic      body_in_ready,
    input  wire logic body_in_last,
    input  wire logic last_packet,

    input  wire logic same_flow,
    input  wire logic first_seq_ok,
    input  wire logic next_seq_ok,

    input  wire logic nearly_full,
    input  wire logic empty,

    output logic      accept,
    output logic      capture_flow,
    output logic      advance_seq,
    output logic      insert_marker,
    output logic      flush,
    output logic      error_out
);

    import irp_pkg::*;

    req_state_e state;
    req_state_e state_next;

    logic handshake;
    logic error;
    // A beat_stage write is still on its way into the queue
    logic write_pending;

    assign body_in_ready = !nearly_full && (state != DRAINING);
    assign handshake     = body_in_valid && body_in_ready;

    // Sequence and flow checks at packet starts
    always_comb begin
        error = 1'b0;
        if (handshake) begin
            case (state)
                WAIT_FIRST: error = !first_seq_ok;
                WAIT_NEXT:  error = !(same_flow && next_seq_ok);
                default:    error = 1'b0;
            endcase
        end
    end

    // The offending beat is dropped and replaced by the marker
    assign accept        = handshake && !error;
    assign insert_marker = error;

    // Key is latched even for a bad first packet so it shows on flow_out
    assign capture_flow  = handshake && (state == WAIT_FIRST);
    assign advance_seq   = accept && (state == WAIT_NEXT);

    always_comb begin
        state_next = state;
        case (state)
            WAIT_FIRST, RECEIVING, WAIT_NEXT: begin
                if (error) begin
                    state_next = DRAINING;
                end else if (accept) begin
                    if (body_in_last) begin
                        state_next = last_packet ? DRAINING : WAIT_NEXT;
                    end else begin
                        state_next = RECEIVING;
                    end
                end
            end
            DRAINING: begin
                // Wait until the final beat or marker has left the queue
                if (empty && !write_pending) begin
                    state_next = WAIT_FIRST;
                end
            end
            default: state_next = WAIT_FIRST;
        endcase
    end

    always_ff @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            state         <= WAIT_FIRST;
            flush         <= 1'b0;
            write_pending <= 1'b0;
            error_out     <= 1'b0;
        end else begin
            state         <= state_next;
            flush         <= error;
            write_pending <= accept || insert_marker;
            if (error) begin
                error_out <= 1'b1;
            end else if (state == DRAINING && state_next == WAIT_FIRST) begin
                error_out <= 1'b0;
            end
        end
    end

    // Errors cannot follow one another since DRAINING blocks input
    flush_single_pulse: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        flush |=> !flush
    );

    // A finished or aborted request blocks input from the next cycle
    no_ready_after_request_end: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (error || (accept && body_in_last && last_packet)) |=> !body_in_ready
    );

endmodule

`default_nettype wire

//--- tb_inference_request_preprocessor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_inference_request_preprocessor;

    import irp_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int STIM_DELAY  = 2;
    localparam int DRAIN_LIMIT = 1000;
    // Beats over all tests: 5 + 12 + 1 + 4 + 4 + 40 + 6
    localparam int TOTAL_BEATS     = 72;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 300;

    logic      axis_aclk = 1'b0;
    logic      axis_resetn;
    beat_t     body_in;
    logic      body_in_valid;
    logic      body_in_ready;
    pkt_meta_t meta_in;
    beat_t     body_out;
    logic      body_out_valid;
    logic      body_out_ready;
    flow_key_t flow_out;
    logic      error_out;

    beat_t       expected_beats[$];
    beat_t       expected_head;
    logic [31:0] data_rng  = 32'd44227;
    logic [31:0] ready_rng = 32'd44227;
    logic        random_ready;
    logic        ready_low_seen;
    logic        error_expected;
    string       current_test;
    int          check_errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          beats_checked;
    flow_key_t   key_a;
    flow_key_t   key_b;
    flow_key_t   key_c;

    inference_request_preprocessor DUT (
        .axis_aclk      (axis_aclk),
        .axis_resetn    (axis_resetn),
        .body_in        (body_in),
        .body_in_valid  (body_in_valid),
        .body_in_ready  (body_in_ready),
        .meta_in        (meta_in),
        .body_out       (body_out),
        .body_out_valid (body_out_valid),
        .body_out_ready (body_out_ready),
        .flow_out       (flow_out),
        .error_out      (error_out)
    );

    always #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic beat_t random_beat(input logic is_last);
        beat_t b;
        data_rng = xorshift32(data_rng);
        b.data[63:32] = data_rng;
        data_rng = xorshift32(data_rng);
        b.data[31:0] = data_rng;
        // Partial keep only on the closing beat of a packet
        b.keep = is_last ? (8'hFF >> data_rng[2:0]) : 8'hFF;
        b.last = is_last;
        return b;
    endfunction

    function automatic flow_key_t random_key();
        logic [$bits(flow_key_t)-1:0] bits;
        for (int i = 0; i < $bits(flow_key_t) / 32; i++) begin
            data_rng = xorshift32(data_rng);
            bits[i*32 +: 32] = data_rng;
        end
        return flow_key_t'(bits);
    endfunction

    // Logical sequence number to wire order
    function automatic logic [15:0] to_network(input int logical);
        return {logical[7:0], logical[15:8]};
    endfunction

    task automatic begin_test(input string name);
        current_test    = name;
        errors_at_start = check_errors;
    endtask

    task automatic finish_test();
        int errs;
        errs = check_errors - errors_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", current_test, errs);
        end
    endtask

    task automatic expect_equal(input string what, input logic [255:0] expected,
                                input logic [255:0] actual);
        value_check: assert (actual === expected) else begin
            check_errors++;
            $display("Error: %s: %s expected %0h, actual %0h",
                     current_test, what, expected, actual);
        end
    endtask

    // Holds the beat until the handshake, checked at the falling edge
    task automatic drive_beat(input beat_t b, input pkt_meta_t m);
        logic taken;
        taken         = 1'b0;
        body_in       = b;
        meta_in       = m;
        body_in_valid = 1'b1;
        while (!taken) begin
            @(negedge axis_aclk);
            if (body_in_ready) begin
                taken = 1'b1;
            end else begin
                ready_low_seen = 1'b1;
            end
            @(posedge axis_aclk);
            #STIM_DELAY;
        end
        body_in_valid = 1'b0;
    endtask

    task automatic send_packet(input flow_key_t key, input int seq, input logic last_pkt,
                               input int n_beats);
        pkt_meta_t m;
        beat_t     b;
        beat_t     exp;
        m.flow        = key;
        m.seq_num     = to_network(seq);
        m.last_packet = last_pkt;
        for (int i = 0; i < n_beats; i++) begin
            b = random_beat(i == n_beats - 1);
            drive_beat(b, m);
            exp      = b;
            // Packet tlast survives only on the final packet
            exp.last = b.last && last_pkt;
            expected_beats.push_back(exp);
        end
    endtask

    // One beat that breaks the request; queued beats give way to the marker
    task automatic send_bad_beat(input flow_key_t key, input int seq);
        pkt_meta_t m;
        beat_t     marker;
        m.flow         = key;
        m.seq_num      = to_network(seq);
        m.last_packet  = 1'b0;
        error_expected = 1'b1;
        drive_beat(random_beat(1'b0), m);
        // The queue still serves its head during the flush cycle
        @(posedge axis_aclk);
        #STIM_DELAY;
        marker.data = '0;
        marker.keep = '0;
        marker.last = 1'b1;
        expected_beats.delete();
        expected_beats.push_back(marker);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_beats.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge axis_aclk);
            cycles++;
        end
        if (expected_beats.size() != 0) begin
            check_errors++;
            $display("%s: output stream stopped with %0d beats still expected",
                     current_test, expected_beats.size());
        end
        @(posedge axis_aclk);
        #STIM_DELAY;
    endtask

    task automatic wait_error_clear();
        int cycles;
        cycles = 0;
        while (error_out && cycles < 20) begin
            @(posedge axis_aclk);
            #STIM_DELAY;
            cycles++;
        end
        if (error_out) begin
            check_errors++;
            $display("%s: error_out stayed high after the marker was read", current_test);
        end
        error_expected = 1'b0;
    endtask

    // Output beat compare, sampled where the stream is stable
    always @(negedge axis_aclk) begin
        if (axis_resetn && body_out_valid && body_out_ready) begin
            if (expected_beats.size() == 0) begin
                check_errors++;
                $display("%s: output beat %0h arrived with nothing expected",
                         current_test, body_out);
            end else begin
                expected_head = expected_beats.pop_front();
                beats_checked++;
                out_beat_check: assert (body_out === expected_head) else begin
                    check_errors++;
                    $display("Error: %s: body_out expected %0h, actual %0h",
                             current_test, expected_head, body_out);
                end
            end
        end
    end

    always @(posedge axis_aclk) begin
        #STIM_DELAY;
        if (random_ready) begin
            ready_rng      = xorshift32(ready_rng);
            body_out_ready = (ready_rng[1:0] == 2'd0);
        end
    end

    // A flush may replace a stalled beat, hence the error_out exception
    out_stable_while_stalled: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn || error_out)
        (body_out_valid && !body_out_ready) |=> (body_out_valid && $stable(body_out))
    ) else begin
        check_errors++;
        $display("%s: output beat changed while body_out_ready was low", current_test);
    end

    no_error_when_clean: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        !error_expected |-> !error_out
    ) else begin
        check_errors++;
        $display("Error: %s: error_out expected 0, actual 1", current_test);
    end

    marker_only_on_error: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (body_out_valid && body_out.keep == '0) |-> (error_out && body_out.last)
    ) else begin
        check_errors++;
        $display("%s: empty beat seen outside an error drain", current_test);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        axis_resetn    = 1'b0;
        body_in        = '0;
        body_in_valid  = 1'b0;
        meta_in        = '0;
        body_out_ready = 1'b1;
        random_ready   = 1'b0;
        ready_low_seen = 1'b0;
        error_expected = 1'b0;
        current_test   = "reset";
        key_a = random_key();
        key_b = key_a;
        key_b.transmission_id = key_a.transmission_id + 32'd1;
        repeat (8) @(posedge axis_aclk);
        #STIM_DELAY;
        axis_resetn = 1'b1;

        begin_test("single_packet");
        send_packet(key_a, 0, 1'b1, 5);
        wait_drain();
        expect_equal("flow_out", 256'(key_a), 256'(flow_out));
        finish_test();

        begin_test("three_packets");
        send_packet(key_a, 0, 1'b0, 4);
        send_packet(key_a, 1, 1'b0, 4);
        send_packet(key_a, 2, 1'b1, 4);
        wait_drain();
        finish_test();

        begin_test("bad_first_seq");
        send_bad_beat(key_b, 1);
        expect_equal("error_out", 256'(1'b1), 256'(error_out));
        expect_equal("flow_out", 256'(key_b), 256'(flow_out));
        wait_drain();
        wait_error_clear();
        finish_test();

        begin_test("wrong_flow");
        body_out_ready = 1'b0;
        send_packet(key_a, 0, 1'b0, 3);
        send_bad_beat(key_b, 1);
        expect_equal("error_out", 256'(1'b1), 256'(error_out));
        expect_equal("flow_out", 256'(key_a), 256'(flow_out));
        body_out_ready = 1'b1;
        wait_drain();
        wait_error_clear();
        finish_test();

        begin_test("skipped_seq");
        body_out_ready = 1'b0;
        send_packet(key_a, 0, 1'b0, 3);
        send_bad_beat(key_a, 2);
        expect_equal("error_out", 256'(1'b1), 256'(error_out));
        body_out_ready = 1'b1;
        wait_drain();
        wait_error_clear();
        finish_test();

        begin_test("backpressure");
        ready_low_seen = 1'b0;
        random_ready   = 1'b1;
        for (int p = 0; p < 4; p++) begin
            send_packet(key_a, p, p == 3, 10);
        end
        expect_equal("body_in_ready low seen", 256'(1'b1), 256'(ready_low_seen));
        random_ready   = 1'b0;
        body_out_ready = 1'b1;
        wait_drain();
        finish_test();

        begin_test("new_flow");
        key_c = random_key();
        send_packet(key_c, 0, 1'b0, 3);
        send_packet(key_c, 1, 1'b1, 3);
        wait_drain();
        expect_equal("flow_out", 256'(key_c), 256'(flow_out));
        finish_test();

        $display("Summary: %0d tests, %0d failed, %0d beats checked, %0d errors",
                 tests_run, tests_failed, beats_checked, check_errors);
        if (check_errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
